// ==== design/alu_macros.svh ====
////////////////////////////////////////
// datapath width and decimal correction
// constants for the pipelined ALU
////////////////////////////////////////

`ifndef ALU_MACROS_SVH
`define ALU_MACROS_SVH

// width of every data word in the pipeline
`define DATA_W 8

// added when the low BCD digit overflows
`define BCD_FIX_LO 8'h06

// added when the high BCD digit overflows
`define BCD_FIX_HI 8'h60

`endif

// ==== design/aluPkg.sv ====
////////////////////////////////////////
// ALU package: data word, operation,
// B-source and status flag types
////////////////////////////////////////

`default_nettype none

`include "alu_macros.svh"

package aluPkg;

	// one data word on any of the buses
	typedef logic [`DATA_W-1:0] byteT;

	// ALU function, one per 6502 control line (SUMS, ANDS, EORS, ORS, SRS)
	typedef enum logic [2:0] {
		opSum,
		opAnd,
		opEor,
		opOr,
		opShr
	} aluOpT;

	// source of the B operand
	typedef enum logic [1:0] {
		bFromDb,
		bFromDbInv,
		bFromAdl
	} bSrcT;

	// subset of P held here, msb first as in the real register
	typedef struct packed {
		logic n;
		logic v;
		logic z;
		logic c;
	} flagsT;

endpackage

`default_nettype wire

// ==== design/operandLatch.sv ====
////////////////////////////////////////
// operandLatch: stage 1, A/B operand
// select and latch
////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module operandLatch import aluPkg::*; (
	input logic phi2,
	input logic rst,
	input logic opStart,
	input aluOpT op,
	input byteT sb,
	input byteT db,
	input byteT adl,
	input logic aZero,
	input bSrcT bSel,
	input logic carryIn,
	input logic decimal,
	output byteT aOp,
	output byteT bOp,
	output aluOpT opOut,
	output logic cin,
	output logic dec,
	output logic valid
);

	byteT aMux;
	byteT bMux;

	// A side is the special bus, or zero when aZero is set
	assign aMux = aZero ? '0 : sb;

	// B side picks data bus, its complement, or address low
	always_comb begin
		case (bSel)
			bFromDb: bMux = db;
			bFromDbInv: bMux = ~db;
			bFromAdl: bMux = adl;
			default: bMux = adl;
		endcase
	end

	// operand registers, payload only
	always_ff @(posedge phi2) begin
		aOp <= aMux;
		bOp <= bMux;
		opOut <= op;
		cin <= carryIn;
		// no decimal subtract here, so inverted B falls back to binary
		dec <= decimal && (bSel != bFromDbInv);
	end

	// stage valid tracks the start strobe
	always_ff @(posedge phi2) begin
		if (rst) begin
			valid <= 1'b0;
		end else begin
			valid <= opStart;
		end
	end

endmodule

`default_nettype wire

// ==== design/aluCore.sv ====
////////////////////////////////////////
// aluCore: stage 2, ALU functions into
// the adder hold register
////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

`include "alu_macros.svh"

module aluCore import aluPkg::*; (
	input logic phi2,
	input logic rst,
	input logic validIn,
	input byteT aOp,
	input byteT bOp,
	input aluOpT opIn,
	input logic cin,
	input logic decIn,
	output byteT sumOut,
	output aluOpT opOut,
	output logic hc,
	output logic acr,
	output logic avr,
	output logic decOut,
	output logic validOut
);

	// nibble width, the half carry comes out of the low one
	localparam int HALF_W = `DATA_W / 2;

	logic [HALF_W:0] loSum;
	logic [HALF_W:0] hiSum;
	byteT aluOut;
	logic hcNext;
	logic acrNext;
	logic avrNext;

	// adder split in two so hc is the low nibble carry
	assign loSum = {1'b0, aOp[HALF_W-1:0]} + {1'b0, bOp[HALF_W-1:0]}
		+ {{HALF_W{1'b0}}, cin};
	assign hiSum = {1'b0, aOp[`DATA_W-1:HALF_W]} + {1'b0, bOp[`DATA_W-1:HALF_W]}
		+ {{HALF_W{1'b0}}, loSum[HALF_W]};

	always_comb begin
		aluOut = '0;
		hcNext = 1'b0;
		acrNext = 1'b0;
		avrNext = 1'b0;
		case (opIn)
			opSum: begin
				aluOut = {hiSum[HALF_W-1:0], loSum[HALF_W-1:0]};
				hcNext = loSum[HALF_W];
				acrNext = hiSum[HALF_W];
				// same sign operands, result sign flipped
				avrNext = (aOp[`DATA_W-1] == bOp[`DATA_W-1])
					&& (aluOut[`DATA_W-1] != aOp[`DATA_W-1]);
			end
			opAnd: aluOut = aOp & bOp;
			opEor: aluOut = aOp ^ bOp;
			opOr: aluOut = aOp | bOp;
			opShr: begin
				// shift A only, bit 0 falls out into the carry
				aluOut = {1'b0, aOp[`DATA_W-1:1]};
				acrNext = aOp[0];
			end
			default: aluOut = '0;
		endcase
	end

	// adder hold register
	always_ff @(posedge phi2) begin
		sumOut <= aluOut;
		opOut <= opIn;
		hc <= hcNext;
		acr <= acrNext;
		avr <= avrNext;
		decOut <= decIn;
	end

	always_ff @(posedge phi2) begin
		if (rst) begin
			validOut <= 1'b0;
		end else begin
			validOut <= validIn;
		end
	end

endmodule

`default_nettype wire

// ==== design/decimalAdjust.sv ====
////////////////////////////////////////
// decimalAdjust: stage 3, BCD fixup of
// decimal sums
////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

`include "alu_macros.svh"

module decimalAdjust import aluPkg::*; (
	input logic phi2,
	input logic rst,
	input logic validIn,
	input logic hc,
	input logic acr,
	input logic avr,
	input logic decIn,
	input byteT sumIn,
	input aluOpT opIn,
	output byteT result,
	output aluOpT opOut,
	output logic carry,
	output logic avrOut,
	output logic validOut
);

	logic bcdAdd;
	logic fixLo;
	logic fixHi;
	byteT adjusted;

	// only decimal sums get corrected
	assign bcdAdd = decIn && (opIn == opSum);

	// low digit past 9, or carried out of the nibble
	assign fixLo = bcdAdd && (hc || (sumIn[3:0] > 4'd9));
	// high digit judged on the binary sum, before the low fix
	assign fixHi = bcdAdd && (acr || (sumIn > 8'h99));

	assign adjusted = sumIn + (fixLo ? `BCD_FIX_LO : '0) + (fixHi ? `BCD_FIX_HI : '0);

	always_ff @(posedge phi2) begin
		result <= adjusted;
		opOut <= opIn;
		// decimal carry, plain acr for everything else
		carry <= acr || fixHi;
		avrOut <= avr;
	end

	always_ff @(posedge phi2) begin
		if (rst) begin
			validOut <= 1'b0;
		end else begin
			validOut <= validIn;
		end
	end

endmodule

`default_nettype wire

// ==== design/accumStatus.sv ====
////////////////////////////////////////
// accumStatus: stage 4, accumulator and
// NVZC status update
////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

`include "alu_macros.svh"

module accumStatus import aluPkg::*; (
	input logic phi2,
	input logic rst,
	input logic validIn,
	input logic carry,
	input logic avr,
	input byteT result,
	input aluOpT opIn,
	output byteT acc,
	output flagsT flags,
	output logic opDone
);

	// accumulator and P register load on each retired op
	always_ff @(posedge phi2) begin
		if (rst) begin
			acc <= '0;
			flags <= '0;
		end else if (validIn) begin
			acc <= result;
			// z and n always follow the new accumulator
			flags.z <= (result == '0);
			flags.n <= result[`DATA_W-1];
			case (opIn)
				opSum: begin
					flags.v <= avr;
					flags.c <= carry;
				end
				opShr: begin
					// top bit is shifted-in zero
					flags.n <= 1'b0;
					flags.c <= carry;
				end
				// logical ops keep v and c
				default: begin
					flags.v <= flags.v;
					flags.c <= flags.c;
				end
			endcase
		end
	end

	// one completion pulse per retired op
	always_ff @(posedge phi2) begin
		if (rst) begin
			opDone <= 1'b0;
		end else begin
			opDone <= validIn;
		end
	end

endmodule

`default_nettype wire

// ==== design/aluDatapath.sv ====
////////////////////////////////////////
// aluDatapath: four-stage 6502-style
// arithmetic pipeline
////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module aluDatapath import aluPkg::*; (
	input logic phi2,
	input logic rst,
	input logic opStart,
	input aluOpT op,
	input byteT sb,
	input byteT db,
	input byteT adl,
	input logic aZero,
	input bSrcT bSel,
	input logic carryIn,
	input logic decimal,
	output byteT acc,
	output flagsT flags,
	output logic opDone
);

	// stage 1 to 2
	byteT aOp;
	byteT bOp;
	aluOpT op1;
	logic cin1;
	logic dec1;
	logic valid1;

	// stage 2 to 3, the adder hold register
	byteT sum2;
	aluOpT op2;
	logic hc2;
	logic acr2;
	logic avr2;
	logic dec2;
	logic valid2;

	// stage 3 to 4
	byteT result3;
	aluOpT op3;
	logic carry3;
	logic avr3;
	logic valid3;

	operandLatch i_operandLatch (
		.phi2(phi2), .rst(rst), .opStart(opStart), .op(op),
		.sb(sb), .db(db), .adl(adl), .aZero(aZero), .bSel(bSel),
		.carryIn(carryIn), .decimal(decimal),
		.aOp(aOp), .bOp(bOp), .opOut(op1), .cin(cin1), .dec(dec1), .valid(valid1)
	);

	aluCore i_aluCore (
		.phi2(phi2), .rst(rst), .validIn(valid1),
		.aOp(aOp), .bOp(bOp), .opIn(op1), .cin(cin1), .decIn(dec1),
		.sumOut(sum2), .opOut(op2), .hc(hc2), .acr(acr2), .avr(avr2),
		.decOut(dec2), .validOut(valid2)
	);

	decimalAdjust i_decimalAdjust (
		.phi2(phi2), .rst(rst), .validIn(valid2),
		.hc(hc2), .acr(acr2), .avr(avr2), .decIn(dec2), .sumIn(sum2), .opIn(op2),
		.result(result3), .opOut(op3), .carry(carry3), .avrOut(avr3), .validOut(valid3)
	);

	accumStatus i_accumStatus (
		.phi2(phi2), .rst(rst), .validIn(valid3),
		.carry(carry3), .avr(avr3), .result(result3), .opIn(op3),
		.acc(acc), .flags(flags), .opDone(opDone)
	);

endmodule

`default_nettype wire

// ==== dv/aluDatapath_checker.sv ====
////////////////////////////////////////
// bound assertions on the ALU pipeline
// latency, reset state and z flag
////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module aluDatapath_checker import aluPkg::*; (
	input logic phi2,
	input logic rst,
	input logic opStart,
	input logic opDone,
	input byteT acc,
	input flagsT flags
);

	// four stages, so a start retires on the fourth sampled edge
	startToDone: assert property (@(posedge phi2) disable iff (rst)
		opStart |-> ##4 opDone)
		else $error("opStart not followed by opDone four edges later");

	// nothing retires in reset or the cycle right after, state stays clear
	resetQuiet: assert property (@(posedge phi2)
		($past(rst) || $past(rst, 2)) |-> (!opDone && acc == '0 && flags == '0))
		else $error("pipeline not quiet around reset");

	// z must track the accumulator on every retired op
	zeroFlag: assert property (@(posedge phi2) disable iff (rst)
		opDone |-> (flags.z == (acc == '0)))
		else $error("z flag disagrees with acc");

endmodule

bind aluDatapath aluDatapath_checker i_aluDatapath_checker (
	.phi2(phi2), .rst(rst), .opStart(opStart), .opDone(opDone),
	.acc(acc), .flags(flags)
);

`default_nettype wire

// ==== dv/aluDatapath_tb.sv ====
////////////////////////////////////////
// testbench for the pipelined ALU,
// table stimulus against a flag model
////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

`include "alu_macros.svh"

module aluDatapath_tb import aluPkg::*; ();

	localparam int CLK_PERIOD = 4;
	localparam int RESET_CYCLES = 8;
	localparam int N_ROWS = 18;
	localparam int N_RAND = 8;
	// ten cycles for each row issued plus reset and slack
	localparam int WATCHDOG_CYCLES = 10 * (2 * N_ROWS + N_RAND) + RESET_CYCLES + 40;

	typedef struct packed {
		aluOpT op;
		byteT sb;
		byteT db;
		byteT adl;
		logic aZero;
		bSrcT bSel;
		logic carryIn;
		logic decimal;
	} rowT;

	// op, sb, db, adl, aZero, bSel, carryIn, decimal
	localparam rowT stimTable [N_ROWS] = '{
		// binary add from each B source and subtract through inverted db
		'{opSum, 8'h12, 8'h34, 8'h00, 1'b0, bFromDb, 1'b0, 1'b0},
		'{opSum, 8'h7F, 8'h00, 8'h01, 1'b0, bFromAdl, 1'b0, 1'b0},
		'{opSum, 8'h50, 8'h30, 8'h00, 1'b0, bFromDbInv, 1'b1, 1'b0},
		'{opSum, 8'hFF, 8'h01, 8'h00, 1'b0, bFromDb, 1'b1, 1'b0},
		'{opSum, 8'h80, 8'h01, 8'h00, 1'b0, bFromDbInv, 1'b1, 1'b0},
		// logical ops keep v and c from above
		'{opAnd, 8'hF0, 8'h3C, 8'h00, 1'b0, bFromDb, 1'b0, 1'b0},
		'{opEor, 8'hFF, 8'hFF, 8'h00, 1'b0, bFromDb, 1'b0, 1'b0},
		'{opOr, 8'h80, 8'h00, 8'h01, 1'b0, bFromAdl, 1'b0, 1'b0},
		// shift of sb and then of a zeroed A
		'{opShr, 8'h81, 8'h00, 8'h00, 1'b0, bFromDb, 1'b0, 1'b0},
		'{opShr, 8'hFF, 8'h00, 8'h00, 1'b1, bFromDb, 1'b0, 1'b0},
		// BCD adds with low fix, both fixes, high fix, half carry and carry in
		'{opSum, 8'h15, 8'h27, 8'h00, 1'b0, bFromDb, 1'b0, 1'b1},
		'{opSum, 8'h58, 8'h46, 8'h00, 1'b0, bFromDb, 1'b0, 1'b1},
		'{opSum, 8'h91, 8'h20, 8'h00, 1'b0, bFromDb, 1'b0, 1'b1},
		'{opSum, 8'h09, 8'h09, 8'h00, 1'b0, bFromDb, 1'b0, 1'b1},
		'{opSum, 8'h99, 8'h01, 8'h00, 1'b0, bFromDb, 1'b1, 1'b1},
		// decimal with inverted B stays binary
		'{opSum, 8'h50, 8'h20, 8'h00, 1'b0, bFromDbInv, 1'b1, 1'b1},
		// logical result of zero and a sum with A forced to zero
		'{opAnd, 8'h55, 8'h00, 8'hAA, 1'b0, bFromAdl, 1'b0, 1'b0},
		'{opSum, 8'h55, 8'h80, 8'h00, 1'b1, bFromDb, 1'b0, 1'b0}
	};

	logic phi2;
	logic rst;
	logic opStart;
	aluOpT op;
	byteT sb;
	byteT db;
	byteT adl;
	logic aZero;
	bSrcT bSel;
	logic carryIn;
	logic decimal;
	byteT acc;
	flagsT flags;
	logic opDone;

	// expected results in issue order
	byteT expAcc[$];
	flagsT expFlags[$];
	flagsT modelFlags;
	integer seed;

	aluDatapath i_aluDatapath (
		.phi2(phi2), .rst(rst), .opStart(opStart), .op(op),
		.sb(sb), .db(db), .adl(adl), .aZero(aZero), .bSel(bSel),
		.carryIn(carryIn), .decimal(decimal),
		.acc(acc), .flags(flags), .opDone(opDone)
	);

	initial begin
		phi2 = 1'b0;
		forever #(CLK_PERIOD / 2) phi2 = ~phi2;
	end

	task automatic abortRun(input string why);
		$display("%s", why);
		$display("TESTS FAILED");
		$fatal(1, "simulation stopped on first error");
	endtask

	task automatic checkByte(input string name, input byteT exp, input byteT act);
		if (act !== exp) begin
			abortRun($sformatf("** Error at time %0t: %s expected %02h, got %02h",
				$time, name, exp, act));
		end
	endtask

	task automatic checkFlags(input string name, input flagsT exp, input flagsT act);
		if (act !== exp) begin
			abortRun($sformatf("** Error at time %0t: %s expected nvzc=%04b, got nvzc=%04b",
				$time, name, exp, act));
		end
	endtask

	// reference model of one op with prev carrying v and c through logical ops
	function automatic void refModel(input rowT r, input flagsT prev,
		output byteT res, output flagsT nf);
		byteT a;
		byteT b;
		logic [`DATA_W:0] sum9;
		logic halfCarry;
		logic fixLo;
		logic fixHi;
		logic useDec;
		a = r.aZero ? '0 : r.sb;
		case (r.bSel)
			bFromDbInv: b = ~r.db;
			bFromAdl: b = r.adl;
			default: b = r.db;
		endcase
		// inverted B means binary since there is no decimal subtract
		useDec = r.decimal && (r.bSel != bFromDbInv);
		nf = prev;
		res = '0;
		case (r.op)
			opSum: begin
				sum9 = {1'b0, a} + {1'b0, b} + {{`DATA_W{1'b0}}, r.carryIn};
				halfCarry = (5'(a[3:0]) + 5'(b[3:0]) + 5'(r.carryIn)) > 5'd15;
				res = sum9[`DATA_W-1:0];
				nf.c = sum9[`DATA_W];
				nf.v = (a[`DATA_W-1] == b[`DATA_W-1]) && (res[`DATA_W-1] != a[`DATA_W-1]);
				if (useDec) begin
					fixLo = halfCarry || (res[3:0] > 4'd9);
					fixHi = nf.c || (res > 8'h99);
					res = res + (fixLo ? `BCD_FIX_LO : 8'h00) + (fixHi ? `BCD_FIX_HI : 8'h00);
					nf.c = nf.c || fixHi;
				end
			end
			opAnd: res = a & b;
			opEor: res = a ^ b;
			opOr: res = a | b;
			default: begin
				// shift right with old bit 0 into c
				res = {1'b0, a[`DATA_W-1:1]};
				nf.c = a[0];
			end
		endcase
		nf.z = (res == '0);
		nf.n = res[`DATA_W-1];
	endfunction

	task automatic issueRow(input rowT r);
		byteT res;
		flagsT nf;
		@(posedge phi2);
		#1;
		opStart = 1'b1;
		op = r.op;
		sb = r.sb;
		db = r.db;
		adl = r.adl;
		aZero = r.aZero;
		bSel = r.bSel;
		carryIn = r.carryIn;
		decimal = r.decimal;
		refModel(r, modelFlags, res, nf);
		modelFlags = nf;
		expAcc.push_back(res);
		expFlags.push_back(nf);
	endtask

	task automatic idleCycle();
		@(posedge phi2);
		#1;
		opStart = 1'b0;
	endtask

	task automatic makeRandomRow(output rowT r);
		logic [31:0] rnd;
		logic [31:0] rnd2;
		rnd = $random(seed);
		rnd2 = $random(seed);
		r.sb = rnd[7:0];
		r.db = rnd[15:8];
		r.adl = rnd[23:16];
		r.aZero = rnd[24];
		r.carryIn = rnd[25];
		r.decimal = rnd[26];
		r.op = aluOpT'(3'(rnd2[7:0] % 8'd5));
		r.bSel = bSrcT'(2'(rnd2[15:8] % 8'd3));
	endtask

	// results sampled mid-cycle away from the rising edge
	always @(negedge phi2) begin
		if (!rst && opDone === 1'b1) begin
			if (expAcc.size() == 0) begin
				abortRun("opDone pulsed with no operation outstanding");
			end else begin
				checkByte("acc", expAcc.pop_front(), acc);
				checkFlags("flags", expFlags.pop_front(), flags);
			end
		end
	end

	initial begin
		#(WATCHDOG_CYCLES * CLK_PERIOD);
		abortRun("watchdog expired before all results were checked");
	end

	initial begin
		rowT r;
		int drainCycles;
		opStart = 1'b0;
		op = opSum;
		sb = '0;
		db = '0;
		adl = '0;
		aZero = 1'b0;
		bSel = bFromDb;
		carryIn = 1'b0;
		decimal = 1'b0;
		rst = 1'b1;
		modelFlags = '0;
		seed = 32'h7f515493;
		repeat (RESET_CYCLES) @(posedge phi2);
		#1;
		rst = 1'b0;
		// state stays clear and nothing retires while idle after reset
		repeat (3) begin
			@(negedge phi2);
			checkByte("acc", '0, acc);
			checkFlags("flags", '0, flags);
			if (opDone !== 1'b0) begin
				abortRun("opDone not low after reset before any opStart");
			end
		end
		// one row per cycle keeps four in flight
		for (int i = 0; i < N_ROWS; i++) begin
			issueRow(stimTable[i]);
		end
		idleCycle();
		// same rows with one to three idle cycles between them
		for (int i = 0; i < N_ROWS; i++) begin
			issueRow(stimTable[i]);
			repeat (i % 3 + 1) idleCycle();
		end
		for (int i = 0; i < N_RAND; i++) begin
			makeRandomRow(r);
			issueRow(r);
		end
		idleCycle();
		// let the tail retire and watch a few quiet cycles for strays
		drainCycles = 0;
		while (expAcc.size() != 0 && drainCycles < 10) begin
			@(negedge phi2);
			drainCycles++;
		end
		repeat (4) @(negedge phi2);
		if (expAcc.size() != 0) begin
			abortRun($sformatf("opDone missing for %0d queued operations", expAcc.size()));
		end else begin
			$display("TESTS PASSED");
			$finish;
		end
	end

endmodule

`default_nettype wire

// ==== src.f ====
+incdir+design
design/aluPkg.sv
design/operandLatch.sv
design/aluCore.sv
design/decimalAdjust.sv
design/accumStatus.sv
design/aluDatapath.sv
dv/aluDatapath_checker.sv
dv/aluDatapath_tb.sv

// ==== Makefile ====
# Verilator build and run of the ALU pipeline testbench

SRCS := $(filter-out +%,$(shell cat src.f)) design/alu_macros.svh
BIN := obj_dir/ValuDatapath_tb

.PHONY: run clean

run: $(BIN)
	./$(BIN)

# rebuilt only when a source or the file list changes
$(BIN): src.f $(SRCS)
	verilator --binary --timing --assert -f src.f \
		--top-module aluDatapath_tb -Mdir obj_dir

clean:
	rm -rf obj_dir
